//--- conv_1x1_layer.f
common/conv_pkg.sv
conv_1x1/pixel_bank_buffer.sv
conv_1x1/weight_loader.sv
conv_1x1/weight_store.sv
conv_1x1/mac_channel_accum.sv
design/conv_1x1_layer.sv
test/conv_1x1_checker.sv
test/conv_1x1_layer_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the conv_1x1_layer testbench with Verilator
verilator --binary --timing --assert --top-module conv_1x1_layer_tb \
  -f conv_1x1_layer.f -o sim_conv_1x1 > build.log 2>&1 \
  || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/sim_conv_1x1 > sim.log 2>&1 ; cat sim.log
grep -q "Checks failed" sim.log && { echo "Simulation FAILED"; exit 1; }
grep -q "All checks passed" sim.log || { echo "Simulation ended without a result"; exit 1; }
echo "Simulation PASSED"

//--- test/conv_1x1_layer_tb.sv
module conv_1x1_layer_tb;

  import conv_pkg::*;

  localparam int CHANNEL_NUM_IN   = 4;
  localparam int CHANNEL_NUM_OUT  = 4;
  localparam int SET_SIZE         = CHANNEL_NUM_IN * CHANNEL_NUM_OUT;
  localparam int RESET_CYCLES     = 10;
  localparam int GAP_CYCLES       = 40;
  localparam int SETTLE_CYCLES    = 4;
  localparam int CYCLES_PER_ENTRY = 60;

  // Weight set kinds
  localparam int W_IDENTITY = 0;
  localparam int W_RANDOM   = 1;
  localparam int W_LARGE    = 2;
  localparam int W_REPEAT   = 3;
  // Pixel kinds
  localparam int P_RANDOM   = 0;
  localparam int P_LARGE    = 1;

  // One table entry, a weight set or a pixel
  typedef struct packed {
    logic                                is_weight;
    logic [2:0]                          test_id;
    logic [5:0]                          gap;
    logic [SET_SIZE-1:0][DATA_WIDTH-1:0] vals;
  } stim_t;

  logic    clk;
  logic    reset;
  logic    valid_in;
  pixel_t  pxl_in;
  logic    valid_weight_in;
  weight_t weight_in;
  pixel_t  pxl_out;
  logic    valid_out;
  logic    test_done;
  logic    run_done;
  logic [2:0] test_id;
  int      pending;
  int      error_count;
  int      check_count;
  integer  seed;
  logic    table_ready;
  stim_t   table_q [$];
  logic [SET_SIZE-1:0][DATA_WIDTH-1:0] cur_set;

  conv_1x1_layer #(
    .CHANNEL_NUM_IN  (CHANNEL_NUM_IN),
    .CHANNEL_NUM_OUT (CHANNEL_NUM_OUT)
  ) u_dut (
    .clk             (clk),
    .reset           (reset),
    .valid_in        (valid_in),
    .pxl_in          (pxl_in),
    .valid_weight_in (valid_weight_in),
    .weight_in       (weight_in),
    .pxl_out         (pxl_out),
    .valid_out       (valid_out)
  );

  conv_1x1_checker #(
    .CHANNEL_NUM_IN  (CHANNEL_NUM_IN),
    .CHANNEL_NUM_OUT (CHANNEL_NUM_OUT)
  ) u_checker (
    .clk             (clk),
    .reset           (reset),
    .valid_in        (valid_in),
    .pxl_in          (pxl_in),
    .valid_weight_in (valid_weight_in),
    .weight_in       (weight_in),
    .pxl_out         (pxl_out),
    .valid_out       (valid_out),
    .test_done       (test_done),
    .test_id         (test_id),
    .run_done        (run_done),
    .pending         (pending),
    .error_count     (error_count),
    .check_count     (check_count)
  );

  initial clk = 1'b0;
  always #2 clk = ~clk;

  ////////////////////
  // Stimulus table
  ////////////////////

  task automatic add_weights(input logic [2:0] id, input int mode);
    stim_t e;
    e           = '0;
    e.is_weight = 1'b1;
    e.test_id   = id;
    for (int k = 0; k < SET_SIZE; k++) begin
      case (mode)
        W_IDENTITY: cur_set[k] = ((k / CHANNEL_NUM_IN) == (k % CHANNEL_NUM_IN)) ? 16'd1 : 16'd0;
        W_RANDOM:   cur_set[k] = 16'($random(seed));
        W_LARGE:    cur_set[k] = 16'hff00 | 16'(k * 7);
        default:    cur_set[k] = cur_set[k];
      endcase
    end
    e.vals = cur_set;
    table_q.push_back(e);
  endtask

  task automatic add_pixel(input logic [2:0] id, input int mode, input int gap);
    stim_t e;
    e         = '0;
    e.test_id = id;
    e.gap     = 6'(gap);
    for (int k = 0; k < CHANNEL_NUM_IN; k++) begin
      if (mode == P_LARGE) begin
        e.vals[k] = 16'hfff0 ^ 16'(k);
      end else begin
        e.vals[k] = 16'($random(seed));
      end
    end
    table_q.push_back(e);
  endtask

  task automatic build_table();
    // Identity weights pass the pixel through
    add_weights(1, W_IDENTITY);
    add_pixel(1, P_RANDOM, GAP_CYCLES);
    add_pixel(1, P_RANDOM, GAP_CYCLES);
    add_weights(2, W_RANDOM);
    add_pixel(2, P_RANDOM, GAP_CYCLES);
    add_pixel(2, P_RANDOM, GAP_CYCLES);
    add_pixel(2, P_RANDOM, GAP_CYCLES);
    // Sums far beyond 16 bits
    add_weights(3, W_LARGE);
    add_pixel(3, P_LARGE, GAP_CYCLES);
    add_pixel(3, P_RANDOM, GAP_CYCLES);
    // Back-to-back pair fills both banks
    add_pixel(4, P_RANDOM, 0);
    add_pixel(4, P_RANDOM, GAP_CYCLES);
    // Same set reloaded while the engine is busy
    add_pixel(5, P_RANDOM, 0);
    add_weights(5, W_REPEAT);
    add_pixel(5, P_RANDOM, GAP_CYCLES);
    // Different set loaded while idle
    add_weights(6, W_RANDOM);
    add_pixel(6, P_RANDOM, GAP_CYCLES);
    add_pixel(6, P_RANDOM, GAP_CYCLES);
  endtask

  ////////////////////
  // Stimulus loop
  ////////////////////

  task automatic apply_entry(input stim_t e);
    if (e.is_weight) begin
      for (int k = 0; k < SET_SIZE; k++) begin
        @(posedge clk);
        valid_in        <= 1'b0;
        valid_weight_in <= 1'b1;
        weight_in       <= e.vals[k];
      end
    end else begin
      for (int k = 0; k < CHANNEL_NUM_IN; k++) begin
        @(posedge clk);
        valid_weight_in <= 1'b0;
        valid_in        <= 1'b1;
        pxl_in          <= e.vals[k];
      end
    end
    if (e.gap != 0) begin
      @(posedge clk);
      valid_in        <= 1'b0;
      valid_weight_in <= 1'b0;
      repeat (int'(e.gap) - 1) @(posedge clk);
    end
  endtask

  // Drain the results of a test, then have the checker report it
  task automatic finish_test(input logic [2:0] id);
    @(posedge clk);
    valid_in        <= 1'b0;
    valid_weight_in <= 1'b0;
    while (pending != 0) begin
      @(posedge clk);
    end
    repeat (SETTLE_CYCLES) @(posedge clk);
    test_id   <= id;
    test_done <= 1'b1;
    @(posedge clk);
    test_done <= 1'b0;
  endtask

  initial begin
    reset           = 1'b1;
    valid_in        = 1'b0;
    pxl_in          = '0;
    valid_weight_in = 1'b0;
    weight_in       = '0;
    test_done       = 1'b0;
    run_done        = 1'b0;
    test_id         = '0;
    cur_set         = '0;
    table_ready     = 1'b0;
    seed            = 37;
    build_table();
    table_ready = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    reset <= 1'b0;
    for (int n = 0; n < table_q.size(); n++) begin
      if (n > 0 && table_q[n].test_id != table_q[n-1].test_id) begin
        finish_test(table_q[n-1].test_id);
      end
      apply_entry(table_q[n]);
    end
    finish_test(table_q[table_q.size()-1].test_id);
    @(posedge clk);
    run_done <= 1'b1;
    @(posedge clk);
    run_done <= 1'b0;
    if (error_count == 0 && check_count > 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

  // Watchdog, scaled by the table length
  initial begin
    wait (table_ready);
    repeat (RESET_CYCLES + table_q.size() * CYCLES_PER_ENTRY) @(posedge clk);
    $display("Timeout: results were still missing after %0d table entries",
             table_q.size());
    $display("Checks failed");
    $finish;
  end

endmodule

//--- test/conv_1x1_checker.sv
module conv_1x1_checker #(
  parameter int CHANNEL_NUM_IN  = 4,
  parameter int CHANNEL_NUM_OUT = 4
) (
  input  logic              clk,
  input  logic              reset,
  input  logic              valid_in,
  input  conv_pkg::pixel_t  pxl_in,
  input  logic              valid_weight_in,
  input  conv_pkg::weight_t weight_in,
  input  conv_pkg::pixel_t  pxl_out,
  input  logic              valid_out,
  input  logic              test_done,
  input  logic [2:0]        test_id,
  input  logic              run_done,
  output int                pending,
  output int                error_count,
  output int                check_count
);

  import conv_pkg::*;

  localparam int SET_SIZE = CHANNEL_NUM_IN * CHANNEL_NUM_OUT;

  weight_t wset [SET_SIZE];
  pixel_t  pix [CHANNEL_NUM_IN];
  pixel_t  expect_q [$];
  pixel_t  exp_val;
  int      w_cnt;
  int      p_cnt;
  int      test_checks;
  int      test_errors;

  // Wrapping sum of products for one output channel
  function automatic pixel_t conv_result(input int o);
    longint unsigned sum;
    longint unsigned p;
    longint unsigned w;
    sum = 0;
    for (int i = 0; i < CHANNEL_NUM_IN; i++) begin
      p   = pix[i];
      w   = wset[o * CHANNEL_NUM_IN + i];
      sum = sum + p * w;
    end
    // Only the low bits of the full sum reach the output
    return sum[DATA_WIDTH-1:0];
  endfunction

  ////////////////////
  // Model and compare
  ////////////////////

  // Inputs and outputs are stable at the falling edge
  always @(negedge clk) begin
    if (reset) begin
      w_cnt       = 0;
      p_cnt       = 0;
      test_checks = 0;
      test_errors = 0;
      error_count = 0;
      check_count = 0;
      expect_q.delete();
    end else begin
      if (valid_weight_in) begin
        wset[w_cnt] = weight_in;
        w_cnt = (w_cnt == SET_SIZE - 1) ? 0 : w_cnt + 1;
      end
      if (valid_in) begin
        pix[p_cnt] = pxl_in;
        if (p_cnt == CHANNEL_NUM_IN - 1) begin
          p_cnt = 0;
          for (int o = 0; o < CHANNEL_NUM_OUT; o++) begin
            expect_q.push_back(conv_result(o));
          end
        end else begin
          p_cnt = p_cnt + 1;
        end
      end
      if (valid_out) begin
        if (expect_q.size() == 0) begin
          $display("Unexpected result 0x%04h at time %0t with no pixel waiting", pxl_out, $time);
          test_errors = test_errors + 1;
          error_count = error_count + 1;
        end else begin
          exp_val     = expect_q.pop_front();
          test_checks = test_checks + 1;
          check_count = check_count + 1;
          if (pxl_out !== exp_val) begin
            $display("Error at time %0t: pxl_out = 0x%04h, expected 0x%04h",
                     $time, pxl_out, exp_val);
            test_errors = test_errors + 1;
            error_count = error_count + 1;
          end
        end
      end
      if (test_done) begin
        if (test_checks == 0) begin
          $display("Test %0d produced no results at all", test_id);
          test_errors = test_errors + 1;
          error_count = error_count + 1;
        end
        $display("Test %0d: %0d results checked, %0d errors, %s", test_id, test_checks,
                 test_errors, (test_errors == 0) ? "ok" : "FAILED");
        test_checks = 0;
        test_errors = 0;
      end
      if (run_done) begin
        $display("Total: %0d results checked, %0d errors", check_count, error_count);
      end
    end
    pending = expect_q.size();
  end

endmodule

//--- design/conv_1x1_layer.sv
module conv_1x1_layer #(
  parameter int CHANNEL_NUM_IN  = 4,
  parameter int CHANNEL_NUM_OUT = 4
) (
  input  logic              clk,
  input  logic              reset,
  input  logic              valid_in,
  input  conv_pkg::pixel_t  pxl_in,
  input  logic              valid_weight_in,
  input  conv_pkg::weight_t weight_in,
  output conv_pkg::pixel_t  pxl_out,
  output logic              valid_out
);

  import conv_pkg::*;

  // Pixel buffer to engine
  logic      bank_full;
  logic      bank_release;
  chan_idx_t rd_chan;
  pixel_t    rd_data;

  // Weight path
  wt_req_t load_req;
  wt_req_t fetch_req;
  logic    load_gnt;
  logic    fetch_gnt;
  weight_t fetch_data;
  logic    weights_loaded;

  pixel_bank_buffer #(
    .CHANNEL_NUM_IN (CHANNEL_NUM_IN)
  ) u_pixel_bank_buffer (
    .clk          (clk),
    .reset        (reset),
    .valid_in     (valid_in),
    .pxl_in       (pxl_in),
    .rd_chan      (rd_chan),
    .bank_release (bank_release),
    .rd_data      (rd_data),
    .bank_full    (bank_full)
  );

  weight_loader #(
    .CHANNEL_NUM_IN  (CHANNEL_NUM_IN),
    .CHANNEL_NUM_OUT (CHANNEL_NUM_OUT)
  ) u_weight_loader (
    .clk             (clk),
    .reset           (reset),
    .valid_weight_in (valid_weight_in),
    .weight_in       (weight_in),
    .load_gnt        (load_gnt),
    .load_req        (load_req),
    .weights_loaded  (weights_loaded)
  );

  weight_store #(
    .CHANNEL_NUM_IN  (CHANNEL_NUM_IN),
    .CHANNEL_NUM_OUT (CHANNEL_NUM_OUT)
  ) u_weight_store (
    .clk        (clk),
    .reset      (reset),
    .load_req   (load_req),
    .fetch_req  (fetch_req),
    .load_gnt   (load_gnt),
    .fetch_gnt  (fetch_gnt),
    .fetch_data (fetch_data)
  );

  mac_channel_accum #(
    .CHANNEL_NUM_IN  (CHANNEL_NUM_IN),
    .CHANNEL_NUM_OUT (CHANNEL_NUM_OUT)
  ) u_mac_channel_accum (
    .clk            (clk),
    .reset          (reset),
    .bank_full      (bank_full),
    .rd_data        (rd_data),
    .weights_loaded (weights_loaded),
    .fetch_gnt      (fetch_gnt),
    .fetch_data     (fetch_data),
    .rd_chan        (rd_chan),
    .bank_release   (bank_release),
    .fetch_req      (fetch_req),
    .pxl_out        (pxl_out),
    .valid_out      (valid_out)
  );

endmodule

//--- conv_1x1/mac_channel_accum.sv
module mac_channel_accum #(
  parameter int CHANNEL_NUM_IN  = 4,
  parameter int CHANNEL_NUM_OUT = 4
) (
  input  logic                clk,
  input  logic                reset,
  input  logic                bank_full,
  input  conv_pkg::pixel_t    rd_data,
  input  logic                weights_loaded,
  input  logic                fetch_gnt,
  input  conv_pkg::weight_t   fetch_data,
  output conv_pkg::chan_idx_t rd_chan,
  output logic                bank_release,
  output conv_pkg::wt_req_t   fetch_req,
  output conv_pkg::pixel_t    pxl_out,
  output logic                valid_out
);

  import conv_pkg::*;

  mac_state_t state;
  chan_idx_t  in_ch;
  chan_idx_t  out_ch;
  pixel_t     pxl_lat;
  acc_t       acc;
  logic       last_in;
  logic       last_out;

  assign last_in  = (in_ch == chan_idx_t'(CHANNEL_NUM_IN - 1));
  assign last_out = (out_ch == chan_idx_t'(CHANNEL_NUM_OUT - 1));

  // Pixel value for the current input channel
  assign rd_chan = in_ch;

  // Weights are stored output-major
  assign fetch_req.req   = (state == FETCH);
  assign fetch_req.write = 1'b0;
  assign fetch_req.addr  = wt_addr_t'(out_ch * CHANNEL_NUM_IN + in_ch);
  assign fetch_req.wdata = '0;

  // Only the low bits go out so the sum wraps
  assign pxl_out      = acc[DATA_WIDTH-1:0];
  assign valid_out    = (state == EMIT);
  assign bank_release = (state == EMIT) && last_out;

  ////////////////////
  // FSM
  ////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      state  <= IDLE;
      in_ch  <= '0;
      out_ch <= '0;
    end else begin
      case (state)
        IDLE: begin
          in_ch  <= '0;
          out_ch <= '0;
          if (bank_full && weights_loaded) begin
            state <= FETCH;
          end
        end
        // Wait here while the loader owns the memory
        FETCH: begin
          if (fetch_gnt) begin
            state <= ACCUM;
          end
        end
        ACCUM: begin
          if (last_in) begin
            in_ch <= '0;
            state <= EMIT;
          end else begin
            in_ch <= in_ch + 1'b1;
            state <= FETCH;
          end
        end
        EMIT: begin
          if (last_out) begin
            out_ch <= '0;
            state  <= IDLE;
          end else begin
            out_ch <= out_ch + 1'b1;
            state  <= FETCH;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  ////////////////////
  // Datapath
  ////////////////////

  always_ff @(posedge clk) begin
    if (state == FETCH && fetch_gnt) begin
      pxl_lat <= rd_data;
    end
    case (state)
      ACCUM:   acc <= acc + acc_t'(pxl_lat) * acc_t'(fetch_data);
      // Fresh sum for every output channel
      IDLE,
      EMIT:    acc <= '0;
      default: acc <= acc;
    endcase
  end

  // Bank stays put until the engine releases it
  a_bank_held: assert property (@(posedge clk) disable iff (reset)
    (state != IDLE) |-> bank_full);

endmodule

//--- conv_1x1/weight_store.sv
module weight_store #(
  parameter int CHANNEL_NUM_IN  = 4,
  parameter int CHANNEL_NUM_OUT = 4
) (
  input  logic              clk,
  input  logic              reset,
  input  conv_pkg::wt_req_t load_req,
  input  conv_pkg::wt_req_t fetch_req,
  output logic              load_gnt,
  output logic              fetch_gnt,
  output conv_pkg::weight_t fetch_data
);

  import conv_pkg::*;

  localparam int DEPTH  = CHANNEL_NUM_IN * CHANNEL_NUM_OUT;
  localparam int AW     = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  weight_t mem [DEPTH];
  wt_req_t gnt_req;

  ////////////////////
  // Arbiter
  ////////////////////

  // Fixed priority, the loader always wins
  assign load_gnt  = load_req.req;
  assign fetch_gnt = fetch_req.req && !load_req.req;

  always_comb begin
    if (load_req.req) begin
      gnt_req = load_req;
    end else begin
      gnt_req = fetch_req;
    end
  end

  ////////////////////
  // Memory port
  ////////////////////

  // One access per cycle, either a write or a read
  always_ff @(posedge clk) begin
    if (gnt_req.req) begin
      if (gnt_req.write) begin
        mem[gnt_req.addr[AW-1:0]] <= gnt_req.wdata;
      end else begin
        fetch_data <= mem[gnt_req.addr[AW-1:0]];
      end
    end
  end

  ////////////////////
  // Checks
  ////////////////////

  a_depth_fits: assert property (@(posedge clk)
    DEPTH <= 256);

  a_one_grant: assert property (@(posedge clk) disable iff (reset)
    !(load_gnt && fetch_gnt));

  a_load_addr: assert property (@(posedge clk) disable iff (reset)
    load_req.req |-> (int'(load_req.addr) < DEPTH));

  a_fetch_addr: assert property (@(posedge clk) disable iff (reset)
    fetch_req.req |-> (int'(fetch_req.addr) < DEPTH));

  // Engine holds its read request until the loader lets go
  a_fetch_held: assert property (@(posedge clk) disable iff (reset)
    (fetch_req.req && !fetch_gnt) |=> fetch_req.req);

endmodule

//--- conv_1x1/weight_loader.sv
module weight_loader #(
  parameter int CHANNEL_NUM_IN  = 4,
  parameter int CHANNEL_NUM_OUT = 4
) (
  input  logic              clk,
  input  logic              reset,
  input  logic              valid_weight_in,
  input  conv_pkg::weight_t weight_in,
  input  logic              load_gnt,
  output conv_pkg::wt_req_t load_req,
  output logic              weights_loaded
);

  import conv_pkg::*;

  localparam int SET_SIZE = CHANNEL_NUM_IN * CHANNEL_NUM_OUT;

  weight_t    q_data [2];
  logic       rd_ptr;
  logic       wr_ptr;
  logic [1:0] count;
  wt_addr_t   wr_addr;
  logic       push;
  logic       pop;

  // A slot frees up in the same cycle as a grant
  assign pop  = load_req.req && load_gnt;
  assign push = valid_weight_in && ((count != 2'd2) || pop);

  assign load_req.req   = (count != 2'd0);
  assign load_req.write = 1'b1;
  assign load_req.addr  = wr_addr;
  assign load_req.wdata = q_data[rd_ptr];

  always_ff @(posedge clk) begin
    if (push) begin
      q_data[wr_ptr] <= weight_in;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      rd_ptr         <= 1'b0;
      wr_ptr         <= 1'b0;
      count          <= 2'd0;
      wr_addr        <= '0;
      weights_loaded <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr <= ~wr_ptr;
      end
      if (pop) begin
        rd_ptr <= ~rd_ptr;
        // Wrap marks a complete set; later sets overwrite in place
        if (wr_addr == wt_addr_t'(SET_SIZE - 1)) begin
          wr_addr        <= '0;
          weights_loaded <= 1'b1;
        end else begin
          wr_addr <= wr_addr + 1'b1;
        end
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  a_no_overrun: assert property (@(posedge clk) disable iff (reset)
    valid_weight_in |-> ((count != 2'd2) || load_gnt));

endmodule

//--- conv_1x1/pixel_bank_buffer.sv
module pixel_bank_buffer #(
  parameter int CHANNEL_NUM_IN = 4
) (
  input  logic                clk,
  input  logic                reset,
  input  logic                valid_in,
  input  conv_pkg::pixel_t    pxl_in,
  input  conv_pkg::chan_idx_t rd_chan,
  input  logic                bank_release,
  output conv_pkg::pixel_t    rd_data,
  output logic                bank_full
);

  import conv_pkg::*;

  localparam int IDX_W = (CHANNEL_NUM_IN > 1) ? $clog2(CHANNEL_NUM_IN) : 1;

  pixel_t           bank [2][CHANNEL_NUM_IN];
  logic [IDX_W-1:0] fill_cnt;
  logic             wr_bank;
  logic             rd_bank;
  logic [1:0]       full;
  logic             wr_en;
  logic             wr_last;

  // Beats into a full write bank are dropped
  assign wr_en   = valid_in && !full[wr_bank];
  assign wr_last = wr_en && (fill_cnt == IDX_W'(CHANNEL_NUM_IN - 1));

  ////////////////////
  // Fill side
  ////////////////////

  always_ff @(posedge clk) begin
    if (wr_en) begin
      bank[wr_bank][fill_cnt] <= pxl_in;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      fill_cnt <= '0;
      wr_bank  <= 1'b0;
    end else if (wr_last) begin
      fill_cnt <= '0;
      wr_bank  <= ~wr_bank;
    end else if (wr_en) begin
      fill_cnt <= fill_cnt + 1'b1;
    end
  end

  // Full flags, one per bank; fill and release never hit the same bank
  always_ff @(posedge clk) begin
    if (reset) begin
      full    <= '0;
      rd_bank <= 1'b0;
    end else begin
      for (int b = 0; b < 2; b++) begin
        if (wr_last && (wr_bank == 1'(b))) begin
          full[b] <= 1'b1;
        end else if (bank_release && (rd_bank == 1'(b))) begin
          full[b] <= 1'b0;
        end
      end
      if (bank_release) begin
        rd_bank <= ~rd_bank;
      end
    end
  end

  ////////////////////
  // Read side
  ////////////////////

  assign bank_full = full[rd_bank];
  assign rd_data   = bank[rd_bank][rd_chan[IDX_W-1:0]];

  // Source must not outrun the engine by more than one pixel
  a_no_write_when_full: assert property (@(posedge clk) disable iff (reset)
    valid_in |-> !(full[0] && full[1]));

endmodule

//--- common/conv_pkg.sv
package conv_pkg;

  ////////////////////
  // Widths
  ////////////////////

  localparam int DATA_WIDTH = 16;
  // Holds 256 products of two 16-bit values
  localparam int ACC_WIDTH  = 40;
  localparam int ADDR_WIDTH = 8;
  localparam int CHAN_WIDTH = 8;

  ////////////////////
  // Data types
  ////////////////////

  // One channel value of a pixel, or one result
  typedef logic [DATA_WIDTH-1:0] pixel_t;
  typedef logic [DATA_WIDTH-1:0] weight_t;
  typedef logic [ACC_WIDTH-1:0]  acc_t;
  typedef logic [ADDR_WIDTH-1:0] wt_addr_t;
  // Shared by input and output channel counters
  typedef logic [CHAN_WIDTH-1:0] chan_idx_t;

  // Weight memory request from either peer
  typedef struct packed {
    logic     req;
    logic     write;
    wt_addr_t addr;
    weight_t  wdata;
  } wt_req_t;

  // Engine FSM
  typedef enum logic [1:0] {
    IDLE,
    FETCH,
    ACCUM,
    EMIT
  } mac_state_t;

endpackage
